/* source/pet_kbd_macros.svh */
`ifndef PET_KBD_MACROS_SVH
`define PET_KBD_MACROS_SVH

// Key matrix of the PET-style machine with 8 columns per row

// Rows 0 to 9 are populated
`define PET_ROWS 10

// PS/2 clock filter

// One high sample followed by three low ones marks an edge
`define PS2_FILTER_DEPTH 4

// Frame recovery

// System clocks without a PS/2 falling edge before a partial frame is dropped
`define PS2_IDLE_CYCLES 4096

`endif

/* source/pet_kbd_pkg.sv */
`default_nettype none

package pet_kbd_pkg;

	// One PS/2 scan code byte
	typedef logic [7:0] scan_code_t;

	// One matrix row
	typedef logic [7:0] row_bits_t;   // Active low with 0 for a pressed key

	// Row address driven by the host
	typedef logic [3:0] row_addr_t;   // Rows 10 to 15 are not populated

	// Function key levels
	typedef logic [11:1] fn_keys_t;   // Bit n is Fn

	// Held modifier levels
	typedef logic [2:0] mod_keys_t;   // Bit 0 shift, bit 1 alt, bit 2 ctrl

	// PS/2 receiver FSM
	typedef enum logic {
		rx_idle,                      // Waiting for the start bit edge
		rx_frame                      // Shifting in the rest of the frame
	} rx_state_t;

endpackage

`default_nettype wire

/* source/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pet_kbd_macros.svh"

module ps2_frame_rx (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     ps2_clk,
	input  wire                     ps2_data,
	output logic                    byte_valid,
	output pet_kbd_pkg::scan_code_t byte_data
);
	import pet_kbd_pkg::*;

	localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES);
	localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`PS2_IDLE_CYCLES - 1);
	localparam logic [`PS2_FILTER_DEPTH-1:0] FALL_PATTERN =
		{1'b1, {(`PS2_FILTER_DEPTH - 1){1'b0}}};

	logic [1:0]                   clk_meta;
	logic [1:0]                   data_meta;
	logic [`PS2_FILTER_DEPTH-1:0] clk_hist;   // Newest sample at bit 0
	logic                         fall_edge;
	logic                         data_bit;
	rx_state_t                    state;
	logic [3:0]                   bit_cnt;    // Bits taken so far in this frame
	logic [IDLE_W-1:0]            idle_cnt;
	logic [9:0]                   frame_sr;   // Start, data, parity
	logic [10:0]                  frame;
	logic                         frame_done;
	logic                         frame_ok;

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_meta <= '0;
			clk_hist <= '0;   // Needs a real high before the first edge
		end else begin
			clk_meta <= {clk_meta[0], ps2_clk};
			clk_hist <= {clk_hist[`PS2_FILTER_DEPTH-2:0], clk_meta[1]};
		end
	end

	always_ff @(posedge clk) begin
		data_meta <= {data_meta[0], ps2_data};
	end

	assign fall_edge = (clk_hist == FALL_PATTERN);
	assign data_bit  = data_meta[1];

	// Stop bit comes straight from the synchronizer
	assign frame      = {data_bit, frame_sr};
	assign frame_done = fall_edge && (state == rx_frame) && (bit_cnt == 4'd10);
	assign frame_ok   = !frame[0] && (^frame[9:1]) && frame[10];

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= rx_idle;
			bit_cnt    <= '0;
			idle_cnt   <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				rx_idle: begin
					idle_cnt <= '0;
					if (fall_edge) begin
						state   <= rx_frame;
						bit_cnt <= 4'd1;   // Start bit taken
					end
				end
				rx_frame: begin
					if (fall_edge) begin
						idle_cnt <= '0;
						if (bit_cnt == 4'd10) begin
							state      <= rx_idle;
							bit_cnt    <= '0;
							byte_valid <= frame_ok;   // Bad frames vanish here
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else if (idle_cnt == IDLE_LAST) begin
						state   <= rx_idle;   // Keyboard went quiet mid-frame
						bit_cnt <= '0;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fall_edge)
			frame_sr <= {data_bit, frame_sr[9:1]};
		if (frame_done)
			byte_data <= frame[8:1];
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (rst)
		byte_valid |=> !byte_valid)
		else $error("byte_valid held for more than one cycle");

endmodule

`default_nettype wire

/* source/scan_event_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_event_decoder (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         byte_valid,
	input  wire pet_kbd_pkg::scan_code_t byte_data,
	output logic                        key_strobe,
	output pet_kbd_pkg::scan_code_t     key_code,
	output logic                        key_release,
	output logic                        shift_held,
	output logic                        shift_lock,
	output pet_kbd_pkg::fn_keys_t       fn_keys,
	output pet_kbd_pkg::mod_keys_t      mod_keys
);
	import pet_kbd_pkg::*;

	localparam scan_code_t BREAK_CODE = 8'hF0;
	localparam scan_code_t EXT_CODE   = 8'hE0;

	logic release_pending;   // F0 seen, next key is a release
	logic is_break;
	logic is_ext;
	logic is_key;

	assign is_break = byte_valid && (byte_data == BREAK_CODE);
	assign is_ext   = byte_valid && (byte_data == EXT_CODE);   // Extended prefix dropped
	assign is_key   = byte_valid && !is_break && !is_ext;

	always_ff @(posedge clk) begin
		if (rst) begin
			key_strobe      <= 1'b0;
			release_pending <= 1'b0;
		end else begin
			key_strobe <= is_key;
			if (is_break)
				release_pending <= 1'b1;
			else if (is_key)
				release_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (is_key) begin
			key_code    <= byte_data;
			key_release <= release_pending;
		end
	end

	// Rows sample the old levels on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			mod_keys   <= '0;
			fn_keys    <= '0;
			shift_lock <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				8'h12, 8'h59: mod_keys[0] <= ~key_release;   // Left and right shift
				8'h11: mod_keys[1] <= ~key_release;   // Alt
				8'h14: mod_keys[2] <= ~key_release;   // Ctrl
				8'h05: fn_keys[1]  <= ~key_release;
				8'h06: fn_keys[2]  <= ~key_release;
				8'h04: fn_keys[3]  <= ~key_release;
				8'h0C: fn_keys[4]  <= ~key_release;
				8'h03: fn_keys[5]  <= ~key_release;
				8'h0B: fn_keys[6]  <= ~key_release;
				8'h83: fn_keys[7]  <= ~key_release;   // F7 has the odd code
				8'h0A: fn_keys[8]  <= ~key_release;
				8'h01: fn_keys[9]  <= ~key_release;
				8'h09: fn_keys[10] <= ~key_release;
				8'h78: fn_keys[11] <= ~key_release;
				8'h58: begin
					if (!key_release)
						shift_lock <= ~shift_lock;   // Caps lock toggles on press
				end
				default: ;
			endcase
		end
	end

	assign shift_held = mod_keys[0];

	a_no_event_on_break: assert property (@(posedge clk) disable iff (rst)
		is_break |=> !key_strobe)
		else $error("key event emitted for a break prefix");

endmodule

`default_nettype wire

/* source/matrix_row.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_row #(
	parameter int ROW_INDEX = 0
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          key_strobe,
	input  wire pet_kbd_pkg::scan_code_t key_code,
	input  wire                          key_release,
	input  wire                          shift_held,
	input  wire                          shift_lock,
	output pet_kbd_pkg::row_bits_t       row_bits
);
	import pet_kbd_pkg::*;

	row_bits_t next_bits;
	logic      unshift_val;   // Target of the plain symbol of a pair
	logic      shift_val;     // Target of the shifted symbol of a pair
	logic      lock_val;

	assign unshift_val = key_release | shift_held;
	assign shift_val   = key_release | ~shift_held;
	assign lock_val    = key_release ^ shift_lock;

	// Only entries on this row touch the bits
	function automatic row_bits_t put(row_bits_t bits, int row, int pos, logic val);
		row_bits_t res;
		res = bits;
		if (row == ROW_INDEX)
			res[pos] = val;
		return res;
	endfunction

	function automatic row_bits_t put_pair(row_bits_t bits, int ur, int up, int sr, int sp);
		row_bits_t res;
		res = put(bits, ur, up, unshift_val);
		res = put(res, sr, sp, shift_val);
		return res;
	endfunction

	// Edit keys also drive the virtual shift at row 8, bit 5
	function automatic row_bits_t put_edit(row_bits_t bits, int row, int pos, logic fixed);
		row_bits_t res;
		res = put(bits, row, pos, key_release);
		res = put(res, 8, 5, key_release ? ~shift_lock : fixed);
		return res;
	endfunction

	always_comb begin
		next_bits = row_bits;
		case (key_code)
			8'h76: next_bits = put_edit(next_bits, 9, 4, 1'b1);   // ESC as STOP
			8'h05: next_bits = put_edit(next_bits, 9, 4, 1'b0);   // F1 as RUN
			8'h06: next_bits = put_edit(next_bits, 0, 6, 1'b0);   // F2 as CLR
			8'h71: next_bits = put_edit(next_bits, 1, 7, 1'b1);   // DEL
			8'h70: next_bits = put_edit(next_bits, 1, 7, 1'b0);   // INS
			8'h6C: next_bits = put_edit(next_bits, 0, 6, 1'b1);   // HOME
			8'h72: next_bits = put_edit(next_bits, 1, 6, 1'b1);   // Cursor down
			8'h75: next_bits = put_edit(next_bits, 1, 6, 1'b0);   // Cursor up
			8'h74: next_bits = put_edit(next_bits, 0, 7, 1'b1);   // Cursor right
			8'h6B: next_bits = put_edit(next_bits, 0, 7, 1'b0);   // Cursor left
			8'h58, 8'h11: next_bits = put(next_bits, 8, 5, lock_val);   // Caps and alt
			8'h14: next_bits = put(next_bits, 8, 0, key_release);   // Ctrl as left shift
			8'h1F: next_bits = put(next_bits, 9, 0, key_release);   // Reverse on/off
			8'h5A: next_bits = put(next_bits, 6, 5, key_release);   // Return
			8'h66: next_bits = put(next_bits, 1, 7, key_release);   // Backspace
			8'h1C: next_bits = put(next_bits, 4, 0, key_release);   // A
			8'h32: next_bits = put(next_bits, 6, 2, key_release);
			8'h21: next_bits = put(next_bits, 6, 1, key_release);
			8'h23: next_bits = put(next_bits, 4, 1, key_release);
			8'h24: next_bits = put(next_bits, 2, 1, key_release);
			8'h2B: next_bits = put(next_bits, 5, 1, key_release);
			8'h34: next_bits = put(next_bits, 4, 2, key_release);
			8'h33: next_bits = put(next_bits, 5, 2, key_release);
			8'h43: next_bits = put(next_bits, 3, 3, key_release);
			8'h3B: next_bits = put(next_bits, 4, 3, key_release);
			8'h42: next_bits = put(next_bits, 5, 3, key_release);
			8'h4B: next_bits = put(next_bits, 4, 4, key_release);
			8'h3A: next_bits = put(next_bits, 6, 3, key_release);
			8'h31: next_bits = put(next_bits, 7, 2, key_release);
			8'h44: next_bits = put(next_bits, 2, 4, key_release);
			8'h4D: next_bits = put(next_bits, 3, 4, key_release);
			8'h15: next_bits = put(next_bits, 2, 0, key_release);
			8'h2D: next_bits = put(next_bits, 3, 1, key_release);
			8'h1B: next_bits = put(next_bits, 5, 0, key_release);
			8'h2C: next_bits = put(next_bits, 2, 2, key_release);
			8'h3C: next_bits = put(next_bits, 2, 3, key_release);
			8'h2A: next_bits = put(next_bits, 7, 1, key_release);
			8'h1D: next_bits = put(next_bits, 3, 0, key_release);
			8'h22: next_bits = put(next_bits, 7, 0, key_release);
			8'h35: next_bits = put(next_bits, 3, 2, key_release);
			8'h1A: next_bits = put(next_bits, 6, 0, key_release);   // Z
			8'h54: next_bits = put(next_bits, 9, 1, key_release);   // Left bracket
			8'h5B: next_bits = put(next_bits, 8, 2, key_release);   // Right bracket
			8'h5D: next_bits = put(next_bits, 1, 3, key_release);   // Backslash
			8'h29: next_bits = put(next_bits, 9, 2, key_release);   // Space
			8'h16: next_bits = put_pair(next_bits, 6, 6, 0, 0);   // 1 and !
			8'h1E: next_bits = put_pair(next_bits, 7, 6, 8, 1);   // 2 and @
			8'h26: next_bits = put_pair(next_bits, 6, 7, 0, 1);
			8'h25: next_bits = put_pair(next_bits, 4, 6, 1, 1);
			8'h2E: next_bits = put_pair(next_bits, 5, 6, 0, 2);
			8'h36: next_bits = put_pair(next_bits, 4, 7, 2, 5);   // 6 and caret
			8'h3D: next_bits = put_pair(next_bits, 2, 6, 0, 3);
			8'h3E: next_bits = put_pair(next_bits, 3, 6, 5, 7);
			8'h46: next_bits = put_pair(next_bits, 2, 7, 0, 4);
			8'h45: next_bits = put_pair(next_bits, 8, 6, 1, 4);   // 0 and )
			8'h41: next_bits = put_pair(next_bits, 7, 3, 9, 3);   // Comma and <
			8'h49: next_bits = put_pair(next_bits, 9, 6, 8, 4);
			8'h4A: next_bits = put_pair(next_bits, 3, 7, 7, 4);
			8'h4C: next_bits = put_pair(next_bits, 6, 4, 5, 4);   // Semicolon and colon
			8'h4E: next_bits = put_pair(next_bits, 8, 7, 0, 5);
			8'h52: next_bits = put_pair(next_bits, 1, 2, 1, 0);   // Quotes
			8'h55: next_bits = put_pair(next_bits, 9, 7, 7, 7);   // = and +
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			row_bits <= '1;   // No key pressed
		else if (key_strobe)
			row_bits <= next_bits;
	end

endmodule

`default_nettype wire

/* source/matrix_readout.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pet_kbd_macros.svh"

module matrix_readout (
	input  wire                         clk,
	input  wire                         rst,
	input  wire pet_kbd_pkg::row_addr_t row_addr,
	input  wire [`PET_ROWS*8-1:0]       rows_flat,   // Row i at bits i*8 and up
	output pet_kbd_pkg::row_bits_t      row_data
);

	// Unpopulated lines float high like a real matrix
	always_comb begin
		if (row_addr < `PET_ROWS)
			row_data = rows_flat[row_addr*8 +: 8];
		else
			row_data = '1;
	end

	// Every row leaves reset with a defined value
	a_rows_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(rows_flat))
		else $error("matrix rows hold unknown bits after reset");

endmodule

`default_nettype wire

/* source/pet_keyboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pet_kbd_macros.svh"

module pet_keyboard (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         ps2_clk,    // Asynchronous from the keyboard
	input  wire                         ps2_data,
	input  wire pet_kbd_pkg::row_addr_t row_addr,
	output pet_kbd_pkg::row_bits_t      row_data,
	output logic                        shift_lock,
	output pet_kbd_pkg::fn_keys_t       fn_keys,
	output pet_kbd_pkg::mod_keys_t      mod_keys
);
	import pet_kbd_pkg::*;

	logic                  byte_valid;
	scan_code_t            byte_data;
	logic                  key_strobe;
	scan_code_t            key_code;
	logic                  key_release;
	logic                  shift_held;
	wire [`PET_ROWS*8-1:0] rows_flat;

	ps2_frame_rx rx_i (
		.clk        (clk),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	scan_event_decoder dec_i (
		.clk         (clk),
		.rst         (rst),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_release (key_release),
		.shift_held  (shift_held),
		.shift_lock  (shift_lock),
		.fn_keys     (fn_keys),
		.mod_keys    (mod_keys)
	);

	for (genvar i = 0; i < `PET_ROWS; i++) begin : g_rows
		matrix_row #(
			.ROW_INDEX (i)
		) row_i (
			.clk         (clk),
			.rst         (rst),
			.key_strobe  (key_strobe),
			.key_code    (key_code),
			.key_release (key_release),
			.shift_held  (shift_held),
			.shift_lock  (shift_lock),
			.row_bits    (rows_flat[i*8 +: 8])
		);
	end

	matrix_readout readout_i (
		.clk       (clk),
		.rst       (rst),
		.row_addr  (row_addr),
		.rows_flat (rows_flat),
		.row_data  (row_data)
	);

endmodule

`default_nettype wire

/* sim/pet_keyboard_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pet_keyboard_tb;
	import pet_kbd_pkg::*;

	localparam int N_TESTS   = 29;
	localparam int HALF_BIT  = 20;   // System clocks per PS/2 clock phase
	localparam int SETTLE    = 50;
	localparam int BUDGET_NS = N_TESTS * 4 * 11 * 40 * 10;
	localparam int MARGIN_NS = N_TESTS * 200 * 10 + 10000;   // Gaps, settling, resets

	logic      clk;
	logic      rst;
	logic      ps2_clk;
	logic      ps2_data;
	row_addr_t row_addr;
	row_bits_t row_data;
	logic      shift_lock;
	fn_keys_t  fn_keys;
	mod_keys_t mod_keys;

	string       t_name [N_TESTS];
	int          t_nbytes [N_TESTS];
	logic [31:0] t_bytes [N_TESTS];   // First byte sent sits highest
	logic        t_bad [N_TESTS];     // Last byte gets wrong parity
	logic        t_reset [N_TESTS];
	row_addr_t   t_row [N_TESTS];
	row_bits_t   t_exp_row [N_TESTS];
	fn_keys_t    t_exp_fn [N_TESTS];
	mod_keys_t   t_exp_mod [N_TESTS];
	logic        t_exp_lock [N_TESTS];
	int          n_loaded;
	int          errors;
	int          checks;
	logic [31:0] lfsr;

	pet_keyboard pet_keyboard_i (
		.clk        (clk),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.row_addr   (row_addr),
		.row_data   (row_data),
		.shift_lock (shift_lock),
		.fn_keys    (fn_keys),
		.mod_keys   (mod_keys)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;   // Inputs move just after the edge
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
	endfunction

	task automatic take_random_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Start, eight data bits LSB first, odd parity, stop
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		logic        parity;
		parity = ~^code;
		if (bad_parity)
			parity = ~parity;
		bits = {1'b1, parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];   // Data changes while the clock is high
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b0;
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic check_value(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %0h, actual %0h", name, field, expected, actual);
		end
	endtask

	task automatic add_entry(input string name, input int nbytes, input logic [31:0] codes,
			input logic bad, input logic do_reset, input int row, input logic [7:0] exp_row,
			input logic [10:0] exp_fn, input logic [2:0] exp_mod, input logic exp_lock);
		if (n_loaded >= N_TESTS) begin
			errors++;
			$display("Stimulus table is full, entry %s was dropped", name);
		end else begin
			t_name[n_loaded]     = name;
			t_nbytes[n_loaded]   = nbytes;
			t_bytes[n_loaded]    = codes;
			t_bad[n_loaded]      = bad;
			t_reset[n_loaded]    = do_reset;
			t_row[n_loaded]      = 4'(row);
			t_exp_row[n_loaded]  = exp_row;
			t_exp_fn[n_loaded]   = exp_fn;
			t_exp_mod[n_loaded]  = exp_mod;
			t_exp_lock[n_loaded] = exp_lock;
			n_loaded++;
		end
	endtask

	// Entries run in order, so each one starts from the state the last one left
	task automatic load_table;
		add_entry("a_press",           1, 32'h1C,       0, 0,  4, 8'hFE, 11'h000, 3'd0, 0);
		add_entry("other_row_idle",    0, 32'h0,        0, 0,  3, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("unused_addr",       0, 32'h0,        0, 0, 12, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("a_release",         2, 32'hF01C,     0, 0,  4, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("shift_press",       1, 32'h12,       0, 0,  0, 8'hFF, 11'h000, 3'd1, 0);
		add_entry("shift_1_press",     1, 32'h16,       0, 0,  0, 8'hFE, 11'h000, 3'd1, 0);
		add_entry("shift_1_row6",      0, 32'h0,        0, 0,  6, 8'hFF, 11'h000, 3'd1, 0);
		add_entry("shift_1_release",   2, 32'hF016,     0, 0,  0, 8'hFF, 11'h000, 3'd1, 0);
		add_entry("shift_release",     2, 32'hF012,     0, 0,  0, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("plain_1_press",     1, 32'h16,       0, 0,  6, 8'hBF, 11'h000, 3'd0, 0);
		add_entry("plain_1_row0",      0, 32'h0,        0, 0,  0, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("plain_1_release",   2, 32'hF016,     0, 0,  6, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("alt_ctrl_f1_press", 3, 32'h111405,   0, 0,  8, 8'hDE, 11'h001, 3'd6, 0);
		add_entry("f1_run_key",        0, 32'h0,        0, 0,  9, 8'hEF, 11'h001, 3'd6, 0);
		add_entry("f1_release",        2, 32'hF005,     0, 0,  9, 8'hFF, 11'h000, 3'd6, 0);
		add_entry("f1_release_row8",   0, 32'h0,        0, 0,  8, 8'hFE, 11'h000, 3'd6, 0);
		add_entry("alt_ctrl_release",  4, 32'hF011F014, 0, 0,  8, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("caps_on",           3, 32'h58F058,   0, 0,  8, 8'hDF, 11'h000, 3'd0, 1);
		add_entry("down_rel_locked",   2, 32'hF072,     0, 0,  8, 8'hDF, 11'h000, 3'd0, 1);
		add_entry("caps_off",          3, 32'h58F058,   0, 0,  8, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("down_rel_unlocked", 2, 32'hF072,     0, 0,  8, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("bad_parity_frame",  1, 32'h1C,       1, 0,  4, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("good_after_bad",    1, 32'h1C,       0, 0,  4, 8'hFE, 11'h000, 3'd0, 0);
		add_entry("hold_shift_f1",     2, 32'h1205,     0, 0,  9, 8'hEF, 11'h001, 3'd1, 0);
		add_entry("hold_caps",         1, 32'h58,       0, 0,  8, 8'hDF, 11'h001, 3'd1, 1);
		add_entry("reset_row4",        0, 32'h0,        0, 1,  4, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("reset_row9",        0, 32'h0,        0, 0,  9, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("reset_row8",        0, 32'h0,        0, 0,  8, 8'hFF, 11'h000, 3'd0, 0);
		add_entry("decode_after_rst",  1, 32'h1C,       0, 0,  4, 8'hFE, 11'h000, 3'd0, 0);
	endtask

	task automatic run_entry(input int k);
		int gap;
		if (t_reset[k]) begin
			rst = 1'b1;
			wait_cycles(3);
			rst = 1'b0;
		end
		for (int b = t_nbytes[k] - 1; b >= 0; b--) begin
			take_random_bits(4, gap);
			if (gap > 0)
				wait_cycles(gap);
			send_frame(t_bytes[k][b*8 +: 8], t_bad[k] && (b == 0));
		end
		wait_cycles(SETTLE);
		row_addr = t_row[k];
		@(negedge clk);   // Combinational readout settles by mid-cycle
		check_value(t_name[k], "row_data", 32'(t_exp_row[k]), 32'(row_data));
		check_value(t_name[k], "fn_keys", 32'(t_exp_fn[k]), 32'(fn_keys));
		check_value(t_name[k], "mod_keys", 32'(t_exp_mod[k]), 32'(mod_keys));
		check_value(t_name[k], "shift_lock", 32'(t_exp_lock[k]), 32'(shift_lock));
		wait_cycles(1);
	endtask

	initial begin
		#(BUDGET_NS + MARGIN_NS);
		$display("Timeout after %0d ns, the tests did not finish (%0d errors so far)",
			BUDGET_NS + MARGIN_NS, errors);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		rst      = 1'b1;
		ps2_clk  = 1'b1;   // Idle bus is high
		ps2_data = 1'b1;
		row_addr = '0;
		errors   = 0;
		checks   = 0;
		n_loaded = 0;
		lfsr     = 32'had36;
		load_table();
		if (n_loaded != N_TESTS) begin
			errors++;
			$display("Stimulus table holds %0d entries instead of %0d", n_loaded, N_TESTS);
		end
		wait_cycles(3);
		rst = 1'b0;
		for (int k = 0; k < n_loaded; k++)
			run_entry(k);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/pet_kbd_pkg.sv
source/ps2_frame_rx.sv
source/scan_event_decoder.sv
source/matrix_row.sv
source/matrix_readout.sv
source/pet_keyboard.sv
sim/pet_keyboard_tb.sv

/* Makefile */
# Verilator build and run of the PET keyboard testbench

VERILATOR ?= verilator
TOP       ?= pet_keyboard_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
